// File: tb/program_golden.hex
// Header: program words, retire records, memory pairs, halt word index, illegal word
// Then program words, retire records (pc rd value), memory pairs (word address, data)
2C 24 04 2B 0000000F
// 0x00 LUI, AUIPC, ADDI x3, ADDI x4
123450B7 00001117 06400193 FF900213
// 0x10 ADD, SUB, AND, OR
004182B3 40418333 0020F3B3 0041E433
// 0x20 XOR, SLT, SLL, SRL
0041C4B3 00322533 00A195B3 00A25633
// 0x30 SLTI, ANDI, ORI, XORI
0321A693 0F027713 7001E793 FFF24813
// 0x40 SLLI, SRLI, BEQ nt, BNE t
01F51893 01C8D913 00418463 00419463
// 0x50 skip, BLT t, skip, BGE nt
00100993 00324463 00100993 00325463
// 0x60 BLT nt, BGE t, skip, BEQ t
0041C463 0041D463 00100993 00318463
// 0x70 skip, BNE nt, JAL, skip
00100993 00319463 00C00A6F 00100993
// 0x80 skip, ADDI x21, JALR, skip
00100993 08800A93 008A8B67 00100993
// 0x90 ADDI x23, SW, SW, LW
10000B93 006BA023 001BA223 000BAC03
// 0xA0 LW, ADD, SW, ECALL
004BAC83 019C0D33 01ABA423 00000073
// Retire trace
00000000 01 12345000
00000004 02 00001004
00000008 03 00000064
0000000C 04 FFFFFFF9
00000010 05 0000005D
00000014 06 0000006B
00000018 07 00001000
0000001C 08 FFFFFFFD
00000020 09 FFFFFF9D
00000024 0A 00000001
00000028 0B 000000C8
0000002C 0C 7FFFFFFC
00000030 0D 00000000
00000034 0E 000000F0
00000038 0F 00000764
0000003C 10 00000006
00000040 11 80000000
00000044 12 00000008
00000048 00 00000000
0000004C 00 00000000
00000054 00 00000000
0000005C 00 00000000
00000060 00 00000000
00000064 00 00000000
0000006C 00 00000000
00000074 00 00000000
00000078 14 0000007C
00000084 15 00000088
00000088 16 0000008C
00000090 17 00000100
00000094 00 00000000
00000098 00 00000000
0000009C 18 0000006B
000000A0 19 12345000
000000A4 1A 1234506B
000000A8 00 00000000
// Memory after the first halt
40 0000006B
41 12345000
42 1234506B
2B 00000073

// File: all.f
+incdir+include
src/core_pkg.sv
src/fetch_unit.sv
src/instr_decode.sv
src/reg_file.sv
src/exec_unit.sv
src/mem_arbiter.sv
src/unified_mem.sv
src/rv_core_top.sv
tb/tb_core.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_core -f all.f -o Vtb_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
    exit 0
fi
exit 1

// File: tb/tb_core.sv
`timescale 1ns/100ps
`include "core_settings.svh"

module tb_core
    import core_pkg::*;
();

    // Golden image layout: counts, then program, retire records, memory pairs
    localparam int GOLDEN_WORDS = 256;
    localparam int HDR_WORDS = 5;

    logic        clk;
    logic        rst;
    logic        run;
    logic        hostReq;
    memReq_t     hostMem;
    logic        hostGrant;
    logic        hostRvalid;
    logic [31:0] rdata;
    logic        retire;
    retire_t     retireInfo;
    logic        halted;
    logic        illegal;

    logic [31:0] golden [GOLDEN_WORDS];
    int          numProg;
    int          numRetire;
    int          numMem;
    int          haltIdx;
    logic [31:0] illegalWord;
    int          retireBase;
    int          memBase;
    int          errors;
    int          checks;
    // Set when a run never reached halt
    logic        timedOut;

    rv_core_top i_rv_core_top (
        .clk(clk), .rst(rst), .run(run), .hostReq(hostReq), .hostMem(hostMem),
        .hostGrant(hostGrant), .hostRvalid(hostRvalid), .rdata(rdata),
        .retire(retire), .retireInfo(retireInfo), .halted(halted), .illegal(illegal)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // Value compare
    task automatic expectWord(input logic [31:0] got, input logic [31:0] want,
                              input string what);
        checks++;
        assert (got === want)
        else
        begin
            errors++;
            $display("Error at time %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    // Condition that must hold, message already in plain words
    task automatic requireTrue(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1)
        else
        begin
            errors++;
            $display("%s (time %0t)", what, $time);
        end
    endtask

    // Reset held 4 cycles, released on a falling edge
    task automatic applyReset();
        rst = 1'b1;
        run = 1'b0;
        hostReq = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    endtask

    // Host has top priority, so the grant comes in the same cycle
    task automatic hostWrite(input int addr, input logic [31:0] data);
        hostReq = 1'b1;
        hostMem.write = 1'b1;
        hostMem.addr = addr[`ADDR_W-1:0];
        hostMem.wdata = data;
        #5;
        requireTrue(hostGrant, $sformatf("host write to word %0d was not granted", addr));
        @(negedge clk);
        hostReq = 1'b0;
    endtask

    // Read data and valid one cycle after the grant
    task automatic hostRead(input int addr, output logic [31:0] data);
        hostReq = 1'b1;
        hostMem.write = 1'b0;
        hostMem.addr = addr[`ADDR_W-1:0];
        hostMem.wdata = '0;
        #5;
        requireTrue(hostGrant, $sformatf("host read of word %0d was not granted", addr));
        @(negedge clk);
        hostReq = 1'b0;
        requireTrue(hostRvalid, $sformatf("host read of word %0d returned no valid", addr));
        data = rdata;
    endtask

    // One retire against the next golden record
    task automatic checkRetire(input int idx);
        int base;
        base = retireBase + 3 * idx;
        if (idx >= numRetire)
        begin
            requireTrue(1'b0, "core retired more instructions than the golden trace holds");
        end
        else
        begin
            expectWord(retireInfo.pc, golden[base], $sformatf("retire %0d pc", idx));
            expectWord({27'd0, retireInfo.rd}, golden[base + 1],
                       $sformatf("retire %0d rd", idx));
            expectWord(retireInfo.value, golden[base + 2], $sformatf("retire %0d value", idx));
        end
    endtask

    // Run until halted, trace checked on every falling edge
    task automatic runProgram(input logic wantIllegal);
        int seen;
        int cycles;
        int limit;
        seen = 0;
        cycles = 0;
        limit = 40 * numRetire + 200;
        run = 1'b1;
        while (!halted && cycles < limit)
        begin
            @(negedge clk);
            cycles++;
            if (retire)
            begin
                checkRetire(seen);
                seen++;
            end
        end
        if (!halted)
        begin
            timedOut = 1'b1;
            errors++;
            $display("Timeout: core did not halt within %0d cycles", limit);
        end
        else
        begin
            expectWord({31'd0, illegal}, {31'd0, wantIllegal}, "illegal flag after halt");
            // Nothing may retire once halted
            repeat (10)
            begin
                @(negedge clk);
                requireTrue(!retire, "an instruction retired after the core halted");
            end
            expectWord(seen, numRetire, "number of retired instructions");
        end
        run = 1'b0;
    endtask

    initial
    begin
        logic [31:0] word;
        clk = 1'b0;
        rst = 1'b1;
        run = 1'b0;
        hostReq = 1'b0;
        hostMem = '0;
        errors = 0;
        checks = 0;
        timedOut = 1'b0;
        $readmemh("tb/program_golden.hex", golden);
        numProg = int'(golden[0]);
        numRetire = int'(golden[1]);
        numMem = int'(golden[2]);
        haltIdx = int'(golden[3]);
        illegalWord = golden[4];
        retireBase = HDR_WORDS + numProg;
        memBase = retireBase + 3 * numRetire;
        requireTrue(numProg > 0 && numRetire > 0, "golden file holds no program or trace");
        applyReset();

        // Program load with run low, then read-back
        for (int k = 0; k < numProg; k++)
        begin
            hostWrite(k, golden[HDR_WORDS + k]);
        end
        for (int k = 0; k < numProg; k++)
        begin
            hostRead(k, word);
            expectWord(word, golden[HDR_WORDS + k], $sformatf("read-back of word %0d", k));
        end

        // First pass ends on ECALL
        runProgram(1'b0);
        if (!timedOut)
        begin
            for (int k = 0; k < numMem; k++)
            begin
                hostRead(int'(golden[memBase + 2 * k]), word);
                expectWord(word, golden[memBase + 2 * k + 1],
                           $sformatf("memory word %0h", golden[memBase + 2 * k]));
            end

            // Second pass, unsupported opcode at the halt point
            applyReset();
            hostWrite(haltIdx, illegalWord);
            runProgram(1'b1);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("ALL CHECKS PASSED");
        end
        else
        begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: src/rv_core_top.sv
`timescale 1ns/100ps

module rv_core_top
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        run,
    input  logic        hostReq,
    input  memReq_t     hostMem,
    output logic        hostGrant,
    output logic        hostRvalid,
    output logic [31:0] rdata,
    output logic        retire,
    output retire_t     retireInfo,
    output logic        halted,
    output logic        illegal
);

    // Fetch to decode
    logic        take;
    logic        redirect;
    logic [31:0] target;
    logic        instrValid;
    instr_u      instr;
    logic [31:0] fetchPc;

    // Decode, register file and exec
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] rs1Val;
    logic [31:0] rs2Val;
    ctrl_t       ctrl;
    logic [31:0] opA;
    logic [31:0] opB;
    logic        we;
    logic [4:0]  wbRd;
    logic [31:0] wbData;

    // Memory side
    logic        fetchReq;
    logic        fetchGrant;
    logic        fetchRvalid;
    memReq_t     fetchMem;
    logic        dataReq;
    logic        dataGrant;
    logic        dataRvalid;
    memReq_t     dataMem;
    memReq_t     memReq;
    logic        memEn;

    fetch_unit i_fetch_unit (
        .clk(clk), .rst(rst), .take(take), .redirect(redirect), .target(target),
        .instrValid(instrValid), .instr(instr), .pc(fetchPc),
        .req(fetchReq), .memReq(fetchMem), .grant(fetchGrant),
        .rvalid(fetchRvalid), .rdata(rdata)
    );

    instr_decode i_instr_decode (
        .clk(clk), .rst(rst), .take(take), .instr(instr), .pc(fetchPc),
        .rs1Val(rs1Val), .rs2Val(rs2Val), .rs1(rs1), .rs2(rs2),
        .ctrl(ctrl), .opA(opA), .opB(opB)
    );

    reg_file i_reg_file (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rs1Val(rs1Val),
        .rs2Val(rs2Val), .we(we), .rd(wbRd), .wdata(wbData)
    );

    exec_unit i_exec_unit (
        .clk(clk), .rst(rst), .run(run), .instrValid(instrValid), .ctrl(ctrl),
        .opA(opA), .opB(opB), .take(take), .redirect(redirect), .target(target),
        .req(dataReq), .memReq(dataMem), .grant(dataGrant), .rvalid(dataRvalid),
        .rdata(rdata), .we(we), .rd(wbRd), .wdata(wbData), .retire(retire),
        .retireInfo(retireInfo), .halted(halted), .illegal(illegal)
    );

    mem_arbiter i_mem_arbiter (
        .clk(clk), .rst(rst), .hostReq(hostReq), .dataReq(dataReq),
        .fetchReq(fetchReq), .hostMem(hostMem), .dataMem(dataMem),
        .fetchMem(fetchMem), .hostGrant(hostGrant), .dataGrant(dataGrant),
        .fetchGrant(fetchGrant), .hostRvalid(hostRvalid), .dataRvalid(dataRvalid),
        .fetchRvalid(fetchRvalid), .memReq(memReq), .memEn(memEn)
    );

    unified_mem i_unified_mem (
        .clk(clk), .en(memEn), .req(memReq), .rdata(rdata)
    );

endmodule

// File: src/unified_mem.sv
`timescale 1ns/100ps
`include "core_settings.svh"

module unified_mem
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        en,
    input  memReq_t     req,
    output logic [31:0] rdata
);

    // Shared instruction and data words
    logic [31:0] mem [`MEM_WORDS];

    // Read data one cycle after the request
    always_ff @(posedge clk)
    begin
        if (en)
        begin
            if (req.write)
            begin
                mem[req.addr] <= req.wdata;
            end
            else
            begin
                rdata <= mem[req.addr];
            end
        end
    end

endmodule

// File: src/mem_arbiter.sv
`timescale 1ns/100ps

module mem_arbiter
    import core_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    hostReq,
    input  logic    dataReq,
    input  logic    fetchReq,
    input  memReq_t hostMem,
    input  memReq_t dataMem,
    input  memReq_t fetchMem,
    output logic    hostGrant,
    output logic    dataGrant,
    output logic    fetchGrant,
    output logic    hostRvalid,
    output logic    dataRvalid,
    output logic    fetchRvalid,
    output memReq_t memReq,
    output logic    memEn
);

    // Owner of last cycle's read, host/data/fetch
    logic [2:0] rdOwner;

    // Host over data over fetch
    assign hostGrant = hostReq;
    assign dataGrant = dataReq && !hostReq;
    assign fetchGrant = fetchReq && !hostReq && !dataReq;
    assign memEn = hostReq || dataReq || fetchReq;

    always_comb
    begin
        if (hostGrant)
        begin
            memReq = hostMem;
        end
        else if (dataGrant)
        begin
            memReq = dataMem;
        end
        else
        begin
            memReq = fetchMem;
        end
    end

    // Writes get no data back
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rdOwner <= 3'b000;
        end
        else
        begin
            rdOwner <= {hostGrant && !hostMem.write,
                        dataGrant && !dataMem.write,
                        fetchGrant && !fetchMem.write};
        end
    end

    assign hostRvalid = rdOwner[2];
    assign dataRvalid = rdOwner[1];
    assign fetchRvalid = rdOwner[0];

    assert property (@(posedge clk) disable iff (rst)
        $onehot0({hostGrant, dataGrant, fetchGrant}))
        else $error("more than one grant");

endmodule

// File: src/exec_unit.sv
`timescale 1ns/100ps
`include "core_settings.svh"

module exec_unit
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        run,
    input  logic        instrValid,
    input  ctrl_t       ctrl,
    input  logic [31:0] opA,
    input  logic [31:0] opB,
    output logic        take,
    output logic        redirect,
    output logic [31:0] target,
    output logic        req,
    output memReq_t     memReq,
    input  logic        grant,
    input  logic        rvalid,
    input  logic [31:0] rdata,
    output logic        we,
    output logic [4:0]  rd,
    output logic [31:0] wdata,
    output logic        retire,
    output retire_t     retireInfo,
    output logic        halted,
    output logic        illegal
);

    typedef enum logic [1:0] {S_IDLE, S_EXEC, S_MEM, S_HALT} state_e;

    state_e      state;
    // ALU, branch or jump finished last cycle
    logic        aluDone;
    logic        loadWait;
    // First run after reset kicks off fetch
    logic        started;
    logic        startPulse;
    logic        memDone;
    logic        brTaken;
    logic [31:0] srcA;
    logic [31:0] srcB;
    logic [31:0] aluRes;
    logic [31:0] wbData;

    assign srcA = ctrl.aluSrcPc ? ctrl.pc : opA;
    assign srcB = ctrl.aluSrcImm ? ctrl.imm : opB;

    always_comb
    begin
        case (ctrl.aluOp)
            ALU_ADD: aluRes = srcA + srcB;
            ALU_SUB: aluRes = srcA - srcB;
            ALU_AND: aluRes = srcA & srcB;
            ALU_OR: aluRes = srcA | srcB;
            ALU_XOR: aluRes = srcA ^ srcB;
            ALU_SLT: aluRes = {31'd0, $signed(srcA) < $signed(srcB)};
            ALU_SLL: aluRes = srcA << srcB[4:0];
            ALU_SRL: aluRes = srcA >> srcB[4:0];
            default: aluRes = srcB;
        endcase
    end

    // Signed compare of the raw register operands
    always_comb
    begin
        case (ctrl.brKind)
            BR_EQ: brTaken = (opA == opB);
            BR_NE: brTaken = (opA != opB);
            BR_LT: brTaken = ($signed(opA) < $signed(opB));
            default: brTaken = ($signed(opA) >= $signed(opB));
        endcase
    end

    // Decode holds ctrl until the next take, so the finish cycle still sees it
    assign startPulse = (state == S_IDLE) && run && !started;
    assign redirect = startPulse || (aluDone && (ctrl.jump || (ctrl.branch && brTaken)));
    assign target = startPulse ? `RESET_PC :
                    ctrl.jumpReg ? {aluRes[31:1], 1'b0} : ctrl.pc + ctrl.imm;
    // Stale prefetch must not be taken while redirecting
    assign take = (state == S_IDLE) && run && started && instrValid && !redirect;

    // Load/store address from rs1 + imm
    assign req = (state == S_MEM) && !loadWait;
    assign memReq.write = ctrl.memWrite;
    assign memReq.addr = aluRes[`ADDR_W+1:2];
    assign memReq.wdata = opB;
    // Store ends at grant, load at returned data
    assign memDone = (state == S_MEM) && (ctrl.memWrite ? grant : rvalid);

    assign wbData = ctrl.memRead ? rdata : (ctrl.jump ? ctrl.pc + 32'd4 : aluRes);

    // Write-back and retire in the same cycle
    assign retire = aluDone || memDone;
    assign we = retire && ctrl.regWrite;
    assign rd = ctrl.rd;
    assign wdata = wbData;
    assign retireInfo.pc = ctrl.pc;
    assign retireInfo.rd = ctrl.regWrite ? ctrl.rd : 5'd0;
    assign retireInfo.value = ctrl.regWrite ? wbData : 32'd0;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= S_IDLE;
            aluDone <= 1'b0;
            loadWait <= 1'b0;
            started <= 1'b0;
            halted <= 1'b0;
            illegal <= 1'b0;
        end
        else
        begin
            aluDone <= 1'b0;
            if (startPulse)
            begin
                started <= 1'b1;
            end
            case (state)
                S_IDLE:
                begin
                    if (take)
                    begin
                        state <= S_EXEC;
                    end
                end
                // ctrl valid this cycle
                S_EXEC:
                begin
                    if (ctrl.halt)
                    begin
                        state <= S_HALT;
                        halted <= 1'b1;
                        illegal <= ctrl.illegal;
                    end
                    else if (ctrl.memRead || ctrl.memWrite)
                    begin
                        state <= S_MEM;
                    end
                    else
                    begin
                        aluDone <= 1'b1;
                        state <= S_IDLE;
                    end
                end
                S_MEM:
                begin
                    if (req && grant && ctrl.memRead)
                    begin
                        loadWait <= 1'b1;
                    end
                    if (memDone)
                    begin
                        loadWait <= 1'b0;
                        state <= S_IDLE;
                    end
                end
                // Halt holds until reset
                default: state <= S_HALT;
            endcase
        end
    end

    // Nothing enters fetch or decode after halt
    assert property (@(posedge clk) disable iff (rst) halted |-> !take && !redirect)
        else $error("take or redirect after halt");

endmodule

// File: src/reg_file.sv
`timescale 1ns/100ps

module reg_file
(
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    output logic [31:0] rs1Val,
    output logic [31:0] rs2Val,
    input  logic        we,
    input  logic [4:0]  rd,
    input  logic [31:0] wdata
);

    logic [31:0] regs [32];

    // Combinational read ports
    assign rs1Val = regs[rs1];
    assign rs2Val = regs[rs2];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int k = 0; k < 32; k++)
            begin
                regs[k] <= '0;
            end
        end
        // x0 stays zero
        else if (we && (rd != 5'd0))
        begin
            regs[rd] <= wdata;
        end
    end

endmodule

// File: src/instr_decode.sv
`timescale 1ns/100ps

module instr_decode
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        take,
    input  instr_u      instr,
    input  logic [31:0] pc,
    input  logic [31:0] rs1Val,
    input  logic [31:0] rs2Val,
    output logic [4:0]  rs1,
    output logic [4:0]  rs2,
    output ctrl_t       ctrl,
    output logic [31:0] opA,
    output logic [31:0] opB
);

    // ADDI x0, x0, 0
    localparam logic [31:0] NOP = 32'h0000_0013;

    localparam logic [6:0] OPC_LUI = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_JAL = 7'b1101111;
    localparam logic [6:0] OPC_JALR = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;
    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    instr_u      instrQ;
    logic [31:0] pcQ;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immU;
    logic [31:0] immJ;

    // Instruction register, loaded once per take
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            instrQ <= NOP;
            pcQ <= '0;
        end
        else if (take)
        begin
            instrQ <= instr;
            pcQ <= pc;
        end
    end

    // Sign-extended immediates per format
    assign immI = {{20{instrQ.i.imm[11]}}, instrQ.i.imm};
    assign immS = {{20{instrQ.s.immHi[6]}}, instrQ.s.immHi, instrQ.s.immLo};
    assign immB = {{19{instrQ.b.imm12}}, instrQ.b.imm12, instrQ.b.imm11,
                   instrQ.b.imm10to5, instrQ.b.imm4to1, 1'b0};
    assign immU = {instrQ.u.imm, 12'b0};
    assign immJ = {{11{instrQ.j.imm20}}, instrQ.j.imm20, instrQ.j.imm19to12,
                   instrQ.j.imm11, instrQ.j.imm10to1, 1'b0};

    // Register addresses straight from the held word
    assign rs1 = instrQ.r.rs1;
    assign rs2 = instrQ.r.rs2;
    assign opA = rs1Val;
    assign opB = rs2Val;

    always_comb
    begin
        logic bad;
        bad = 1'b0;
        ctrl = '0;
        ctrl.pc = pcQ;
        ctrl.rd = instrQ.r.rd;
        ctrl.imm = immI;
        ctrl.aluOp = ALU_ADD;
        ctrl.brKind = BR_EQ;
        case (instrQ.r.opcode)
            OPC_LUI:
            begin
                ctrl.imm = immU;
                ctrl.aluOp = ALU_PASSB;
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            // pc + upper immediate
            OPC_AUIPC:
            begin
                ctrl.imm = immU;
                ctrl.aluSrcPc = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            OPC_JAL:
            begin
                ctrl.imm = immJ;
                ctrl.jump = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            // Target from rs1 + imm through the ALU
            OPC_JALR:
            begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.jump = 1'b1;
                ctrl.jumpReg = 1'b1;
                ctrl.regWrite = 1'b1;
                bad = (instrQ.i.funct3 != 3'b000);
            end
            OPC_BRANCH:
            begin
                ctrl.imm = immB;
                ctrl.branch = 1'b1;
                case (instrQ.b.funct3)
                    3'b000: ctrl.brKind = BR_EQ;
                    3'b001: ctrl.brKind = BR_NE;
                    3'b100: ctrl.brKind = BR_LT;
                    3'b101: ctrl.brKind = BR_GE;
                    // Unsigned compares not supported
                    default: bad = 1'b1;
                endcase
            end
            // Word loads only
            OPC_LOAD:
            begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.regWrite = 1'b1;
                bad = (instrQ.i.funct3 != 3'b010);
            end
            OPC_STORE:
            begin
                ctrl.imm = immS;
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWrite = 1'b1;
                bad = (instrQ.s.funct3 != 3'b010);
            end
            OPC_OPIMM:
            begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite = 1'b1;
                case (instrQ.i.funct3)
                    3'b000: ctrl.aluOp = ALU_ADD;
                    3'b010: ctrl.aluOp = ALU_SLT;
                    3'b100: ctrl.aluOp = ALU_XOR;
                    3'b110: ctrl.aluOp = ALU_OR;
                    3'b111: ctrl.aluOp = ALU_AND;
                    // Shifts, SRAI falls out as illegal
                    3'b001:
                    begin
                        ctrl.aluOp = ALU_SLL;
                        bad = (instrQ.r.funct7 != 7'd0);
                    end
                    3'b101:
                    begin
                        ctrl.aluOp = ALU_SRL;
                        bad = (instrQ.r.funct7 != 7'd0);
                    end
                    default: bad = 1'b1;
                endcase
            end
            OPC_OP:
            begin
                ctrl.regWrite = 1'b1;
                case ({instrQ.r.funct7, instrQ.r.funct3})
                    10'b0000000_000: ctrl.aluOp = ALU_ADD;
                    10'b0100000_000: ctrl.aluOp = ALU_SUB;
                    10'b0000000_111: ctrl.aluOp = ALU_AND;
                    10'b0000000_110: ctrl.aluOp = ALU_OR;
                    10'b0000000_100: ctrl.aluOp = ALU_XOR;
                    10'b0000000_010: ctrl.aluOp = ALU_SLT;
                    10'b0000000_001: ctrl.aluOp = ALU_SLL;
                    10'b0000000_101: ctrl.aluOp = ALU_SRL;
                    default: bad = 1'b1;
                endcase
            end
            // Exact ECALL encoding only
            OPC_SYSTEM:
            begin
                ctrl.halt = 1'b1;
                bad = (instrQ != 32'h0000_0073);
            end
            default: bad = 1'b1;
        endcase
        // Illegal encodings halt with no side effects
        if (bad)
        begin
            ctrl.halt = 1'b1;
            ctrl.illegal = 1'b1;
            ctrl.regWrite = 1'b0;
            ctrl.memRead = 1'b0;
            ctrl.memWrite = 1'b0;
            ctrl.branch = 1'b0;
            ctrl.jump = 1'b0;
        end
    end

endmodule

// File: src/fetch_unit.sv
`timescale 1ns/100ps
`include "core_settings.svh"

module fetch_unit
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        take,
    input  logic        redirect,
    input  logic [31:0] target,
    output logic        instrValid,
    output instr_u      instr,
    output logic [31:0] pc,
    output logic        req,
    output memReq_t     memReq,
    input  logic        grant,
    input  logic        rvalid,
    input  logic [31:0] rdata
);

    // Byte address of the next word to request
    logic [31:0] reqPc;
    logic        bufValid;
    // Read granted last cycle, data due now
    logic        pending;
    // Held off until the first redirect after reset
    logic        armed;

    // One word ahead, never two reads in flight
    assign req = armed && !bufValid && !pending && !redirect;

    // Fetch only reads
    assign memReq.write = 1'b0;
    assign memReq.addr = reqPc[`ADDR_W+1:2];
    assign memReq.wdata = '0;

    assign instrValid = bufValid;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            reqPc <= `RESET_PC;
            pc <= `RESET_PC;
            bufValid <= 1'b0;
            pending <= 1'b0;
            armed <= 1'b0;
        end
        else
        begin
            pending <= req && grant;
            if (redirect)
            begin
                // New stream, a read landing now is stale
                armed <= 1'b1;
                reqPc <= target;
                bufValid <= 1'b0;
            end
            else if (rvalid)
            begin
                bufValid <= 1'b1;
                pc <= reqPc;
                reqPc <= reqPc + 32'd4;
            end
            else if (take)
            begin
                bufValid <= 1'b0;
            end
        end
    end

    // Prefetched word
    always_ff @(posedge clk)
    begin
        if (rvalid)
        begin
            instr <= rdata;
        end
    end

    // Arbiter only returns data for a read this unit was granted
    assert property (@(posedge clk) disable iff (rst) rvalid |-> pending)
        else $error("fetch rvalid without outstanding read");

endmodule

// File: src/core_pkg.sv
`include "core_settings.svh"

package core_pkg;

    // R-type layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rType_t;

    // I-type layout, also loads, JALR and ECALL
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iType_t;

    // S-type layout, immediate split around rs2/rs1
    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sType_t;

    // B-type layout, scrambled branch offset
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bType_t;

    // U-type layout
    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uType_t;

    // J-type layout
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jType_t;

    // One instruction word seen through every format
    typedef union packed {
        rType_t r;
        iType_t i;
        sType_t s;
        bType_t b;
        uType_t u;
        jType_t j;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASSB
    } aluOp_e;

    typedef enum logic [1:0] {
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE
    } brKind_e;

    // Decoded control for one instruction
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] imm;
        logic [4:0]  rd;
        aluOp_e      aluOp;
        logic        aluSrcImm;
        logic        aluSrcPc;
        logic        regWrite;
        logic        memRead;
        logic        memWrite;
        logic        branch;
        brKind_e     brKind;
        logic        jump;
        logic        jumpReg;
        logic        halt;
        logic        illegal;
    } ctrl_t;

    // Word request toward the arbiter
    typedef struct packed {
        logic              write;
        logic [`ADDR_W-1:0] addr;
        logic [31:0]       wdata;
    } memReq_t;

    // Retired instruction record
    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] value;
    } retire_t;

endpackage

// File: include/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Unified memory depth in 32-bit words
`define MEM_WORDS 256

// Word address width into the unified memory
`define ADDR_W 8

// Byte address of the first instruction fetch
`define RESET_PC 32'h0000_0000

`endif
